// File: Bender.yml
package:
  name: ooo_rv32i_core

sources:
  - logic/rv32i_types.sv
  - logic/ooo_params_pkg.sv
  - logic/fetch.sv
  - logic/dispatch.sv
  - logic/alu_rs.sv
  - logic/rob.sv
  - logic/regfile_scoreboard.sv
  - logic/cpu.sv
  - target: test
    files:
      - bench/cpu_checker.sv
      - bench/cpu_tb.sv

// File: bench/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
  input logic       clk,
  input logic       rst_n,
  input logic [3:0] imem_rmask,
  input logic       imem_resp,
  input logic       commit_valid
);

  logic outstanding;
  logic failed = 1'b0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 1'b0;
    end else if (imem_rmask != 4'h0) begin
      outstanding <= 1'b1;
    end else if (imem_resp) begin
      outstanding <= 1'b0;
    end
  end

  rmask_whole: assert property (@(posedge clk) disable iff (!rst_n)
    imem_rmask == 4'h0 || imem_rmask == 4'hf)
    else begin
      $error("imem_rmask is not a whole-word mask");
      failed = 1'b1;
    end

  one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding |-> imem_rmask == 4'h0)
    else begin
      $error("second imem request before the response");
      failed = 1'b1;
    end

  quiet_reset: assert property (@(posedge clk) !rst_n |-> !commit_valid)
    else begin
      $error("commit_valid high during reset");
      failed = 1'b1;
    end

endmodule

bind cpu cpu_checker i_checker (.*);

`default_nettype wire

// File: bench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  localparam int prog_len        = 300;
  localparam int watchdog_cycles = prog_len * 4 * 10;
  localparam logic [31:0] nop_word = 32'h00000013;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [31:0] imem_addr;
  logic [3:0]  imem_rmask;
  logic [31:0] imem_rdata;
  logic        imem_resp;
  logic        commit_valid;
  logic [31:0] commit_pc;
  logic [4:0]  commit_rd_s;
  logic [31:0] commit_rd_v;

  integer      seed;
  logic [31:0] prog [prog_len];
  logic [31:0] iss_regs [32];

  cpu i_dut (.*);

  always #50 clk = ~clk;

  // random lui, op-imm or op on x0..x7
  function automatic logic [31:0] make_instr();
    rv32i_types::instr_t w;
    logic [31:0] r;
    w = $random(seed);
    r = $random(seed);
    w.r.rd  = {2'b00, r[4:2]};
    w.r.rs1 = {2'b00, r[7:5]};
    case ($unsigned(r[31:16]) % 3)
      0: w.r.opcode = rv32i_types::op_lui;
      1: begin
        w.i.opcode = rv32i_types::op_imm;
        if (w.i.funct3 == rv32i_types::f3_sll) begin
          w.i.imm12[11:5] = 7'h00;
        end else if (w.i.funct3 == rv32i_types::f3_sr) begin
          w.i.imm12[11:5] = r[11] ? 7'h20 : 7'h00;
        end
      end
      default: begin
        w.r.opcode = rv32i_types::op_reg;
        w.r.rs2    = {2'b00, r[10:8]};
        if (r[11] && (w.r.funct3 == rv32i_types::f3_add || w.r.funct3 == rv32i_types::f3_sr))
          w.r.funct7 = 7'h20;
        else
          w.r.funct7 = 7'h00;
      end
    endcase
    return w;
  endfunction

  // in-order reference result of one instruction
  function automatic logic [31:0] iss_result(input logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    logic        is_op;
    is_op = w[6:0] == rv32i_types::op_reg;
    a = iss_regs[w[19:15]];
    b = is_op ? iss_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
    if (w[6:0] == rv32i_types::op_lui) return {w[31:12], 12'h000};
    case (w[14:12])
      3'b000: begin
        if (is_op && w[30]) return a - b;
        return a + b;
      end
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: begin
        if (w[30]) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    if (addr[31:2] < prog_len) return prog[addr[31:2]];
    return nop_word;
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error %s expected %h actual %h", name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_reg(input string name, input logic [4:0] exp, input logic [4:0] act);
    if (exp !== act) begin
      $display("error %s expected %0d actual %0d", name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "register index mismatch");
    end
  endtask

  // imem model answers after 1 to 4 cycles
  initial begin : mem_model
    logic [31:0] addr;
    int unsigned delay;
    imem_resp  = 1'b0;
    imem_rdata = '0;
    forever begin
      @(negedge clk);
      if (rst_n && imem_rmask != 4'h0) begin
        addr  = imem_addr;
        delay = 1 + ($unsigned($random(seed)) % 4);
        @(posedge clk);
        repeat (delay - 1) @(posedge clk);
        #1;
        imem_resp  = 1'b1;
        imem_rdata = mem_word(addr);
        @(posedge clk);
        #1;
        imem_resp  = 1'b0;
      end
    end
  end

  initial begin : assertion_watch
    wait (i_dut.i_checker.failed === 1'b1);
    $display("a bound assertion on the cpu ports failed");
    $display("TEST RESULT: FAIL");
    $fatal(1, "assertion failure");
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired before all program instructions committed");
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

  initial begin : main
    logic [31:0] w;
    logic [31:0] exp_v;
    int          n;
    rst_n = 1'b0;
    seed  = 32'hfd668d02;
    for (int i = 0; i < prog_len; i++) prog[i] = make_instr();
    for (int i = 0; i < 32; i++) iss_regs[i] = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    n = 0;
    while (n < prog_len) begin
      @(negedge clk);
      if (commit_valid) begin
        w     = prog[n];
        exp_v = iss_result(w);
        check_word($sformatf("commit %0d pc", n), n * 4, commit_pc);
        check_reg($sformatf("commit %0d rd", n), w[11:7], commit_rd_s);
        check_word($sformatf("commit %0d value", n), exp_v, commit_rd_v);
        // x0 keeps reading as zero
        if (w[11:7] != 5'd0) iss_regs[w[11:7]] = exp_v;
        n++;
      end
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/alu_rs.sv
`timescale 1ns/1ps
`default_nettype none

module alu_rs (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rs_issue,
  input  logic [6:0]  issue_opcode,
  input  logic [2:0]  issue_funct3,
  input  logic [6:0]  issue_funct7,
  input  logic [31:0] issue_imm,
  input  logic [ooo_params_pkg::rob_tag_w-1:0] issue_rob,
  input  logic [31:0] rs1_v,
  input  logic        rs1_ready,
  input  logic [ooo_params_pkg::rob_tag_w-1:0] rs1_rob,
  input  logic        rs1_rob_ready,
  input  logic [31:0] rs1_rob_v,
  input  logic [31:0] rs2_v,
  input  logic        rs2_ready,
  input  logic [ooo_params_pkg::rob_tag_w-1:0] rs2_rob,
  input  logic        rs2_rob_ready,
  input  logic [31:0] rs2_rob_v,
  output logic        rs_full,
  output logic        cdb_valid,
  output logic [ooo_params_pkg::rob_tag_w-1:0] cdb_rob,
  output logic [31:0] cdb_rd_v
);

  logic        valid [ooo_params_pkg::rs_depth];
  logic        rdy [ooo_params_pkg::rs_depth];
  // older[i][j] set when entry i was written before entry j
  logic        older [ooo_params_pkg::rs_depth][ooo_params_pkg::rs_depth];
  logic [2:0]  e_f3 [ooo_params_pkg::rs_depth];
  logic        e_alt [ooo_params_pkg::rs_depth];
  logic [31:0] a_v [ooo_params_pkg::rs_depth];
  logic [31:0] b_v [ooo_params_pkg::rs_depth];
  logic        a_rdy [ooo_params_pkg::rs_depth];
  logic        b_rdy [ooo_params_pkg::rs_depth];
  logic [ooo_params_pkg::rob_tag_w-1:0] a_rob [ooo_params_pkg::rs_depth];
  logic [ooo_params_pkg::rob_tag_w-1:0] b_rob [ooo_params_pkg::rs_depth];
  logic [ooo_params_pkg::rob_tag_w-1:0] e_rob [ooo_params_pkg::rs_depth];
  logic [ooo_params_pkg::rs_idx_w-1:0]  slot;
  logic [ooo_params_pkg::rs_idx_w-1:0]  sel;
  logic        sel_ok;
  logic [31:0] new_a;
  logic [31:0] new_b;
  logic        new_a_rdy;
  logic        new_b_rdy;
  logic [2:0]  new_f3;
  logic        new_alt;
  logic [31:0] alu_f;

  // regfile first, then a written-back rob entry, then this cycle's bus
  function automatic logic [32:0] pick(input logic rf_rdy, input logic [31:0] rf_v,
                                       input logic rob_rdy, input logic [31:0] rob_v,
                                       input logic [ooo_params_pkg::rob_tag_w-1:0] tag);
    if (rf_rdy) return {1'b1, rf_v};
    if (rob_rdy) return {1'b1, rob_v};
    if (cdb_valid && cdb_rob == tag) return {1'b1, cdb_rd_v};
    return {1'b0, rf_v};
  endfunction

  always_comb begin
    {new_a_rdy, new_a} = pick(rs1_ready, rs1_v, rs1_rob_ready, rs1_rob_v, rs1_rob);
    if (issue_opcode == rv32i_types::op_reg) begin
      {new_b_rdy, new_b} = pick(rs2_ready, rs2_v, rs2_rob_ready, rs2_rob_v, rs2_rob);
    end else begin
      {new_b_rdy, new_b} = {1'b1, issue_imm};
    end
  end

  // lui is an add onto x0
  assign new_f3  = (issue_opcode == rv32i_types::op_lui) ? rv32i_types::f3_add : issue_funct3;
  assign new_alt = issue_funct7[5] && (issue_opcode == rv32i_types::op_reg ||
                   (issue_opcode == rv32i_types::op_imm && issue_funct3 == rv32i_types::f3_sr));

  always_comb begin
    rs_full = 1'b1;
    slot    = '0;
    for (int i = ooo_params_pkg::rs_depth - 1; i >= 0; i--) begin
      rdy[i] = valid[i] && a_rdy[i] && b_rdy[i];
      if (!valid[i]) begin
        rs_full = 1'b0;
        slot    = i[ooo_params_pkg::rs_idx_w-1:0];
      end
    end
  end

  // oldest ready entry
  always_comb begin
    logic beaten;
    sel_ok = 1'b0;
    sel    = '0;
    for (int i = 0; i < ooo_params_pkg::rs_depth; i++) begin
      beaten = 1'b0;
      for (int j = 0; j < ooo_params_pkg::rs_depth; j++) begin
        if (j != i && rdy[j] && older[j][i]) beaten = 1'b1;
      end
      if (rdy[i] && !beaten) begin
        sel_ok = 1'b1;
        sel    = i[ooo_params_pkg::rs_idx_w-1:0];
      end
    end
  end

  always_comb begin
    logic [31:0] op_a;
    logic [31:0] op_b;
    op_a = a_v[sel];
    op_b = b_v[sel];
    case (e_f3[sel])
      rv32i_types::f3_add:  alu_f = e_alt[sel] ? op_a - op_b : op_a + op_b;
      rv32i_types::f3_sll:  alu_f = op_a << op_b[4:0];
      rv32i_types::f3_slt:  alu_f = {31'd0, $signed(op_a) < $signed(op_b)};
      rv32i_types::f3_sltu: alu_f = {31'd0, op_a < op_b};
      rv32i_types::f3_xor:  alu_f = op_a ^ op_b;
      rv32i_types::f3_sr: begin
        if (e_alt[sel]) alu_f = $signed(op_a) >>> op_b[4:0];
        else alu_f = op_a >> op_b[4:0];
      end
      rv32i_types::f3_or:   alu_f = op_a | op_b;
      default:              alu_f = op_a & op_b;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cdb_valid <= 1'b0;
      for (int i = 0; i < ooo_params_pkg::rs_depth; i++) begin
        valid[i] <= 1'b0;
        for (int j = 0; j < ooo_params_pkg::rs_depth; j++) older[i][j] <= 1'b0;
      end
    end else begin
      cdb_valid <= sel_ok;
      if (sel_ok) valid[sel] <= 1'b0;
      if (rs_issue) begin
        valid[slot] <= 1'b1;
        for (int j = 0; j < ooo_params_pkg::rs_depth; j++) begin
          if (j != slot) begin
            older[slot][j] <= 1'b0;
            older[j][slot] <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    // wakeup from the result bus
    for (int i = 0; i < ooo_params_pkg::rs_depth; i++) begin
      if (cdb_valid && !a_rdy[i] && a_rob[i] == cdb_rob) begin
        a_v[i]   <= cdb_rd_v;
        a_rdy[i] <= 1'b1;
      end
      if (cdb_valid && !b_rdy[i] && b_rob[i] == cdb_rob) begin
        b_v[i]   <= cdb_rd_v;
        b_rdy[i] <= 1'b1;
      end
    end
    if (rs_issue) begin
      a_v[slot]   <= new_a;
      a_rdy[slot] <= new_a_rdy;
      a_rob[slot] <= rs1_rob;
      b_v[slot]   <= new_b;
      b_rdy[slot] <= new_b_rdy;
      b_rob[slot] <= rs2_rob;
      e_rob[slot] <= issue_rob;
      e_f3[slot]  <= new_f3;
      e_alt[slot] <= new_alt;
    end
    cdb_rob  <= e_rob[sel];
    cdb_rd_v <= alu_f;
  end

endmodule

`default_nettype wire

// File: logic/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input  logic        clk,
  input  logic        rst_n,

  output logic [31:0] imem_addr,
  output logic [3:0]  imem_rmask,
  input  logic [31:0] imem_rdata,
  input  logic        imem_resp,

  output logic        commit_valid,
  output logic [31:0] commit_pc,
  output logic [4:0]  commit_rd_s,
  output logic [31:0] commit_rd_v
);

  // queue head
  logic        instr_valid;
  logic        instr_pop;
  logic [31:0] issue_pc;
  logic [6:0]  issue_opcode;
  logic [2:0]  issue_funct3;
  logic [6:0]  issue_funct7;
  logic [31:0] issue_imm;
  logic [4:0]  issue_rs1_s;
  logic [4:0]  issue_rs2_s;
  logic [4:0]  issue_rd_s;

  // dispatch
  logic rs_full;
  logic rob_full;
  logic rs_issue;
  logic rob_push;
  logic [ooo_params_pkg::rob_tag_w-1:0] issue_rob;

  // operands
  logic [31:0] rs1_v;
  logic        rs1_ready;
  logic [ooo_params_pkg::rob_tag_w-1:0] rs1_rob;
  logic        rs1_rob_ready;
  logic [31:0] rs1_rob_v;
  logic [31:0] rs2_v;
  logic        rs2_ready;
  logic [ooo_params_pkg::rob_tag_w-1:0] rs2_rob;
  logic        rs2_rob_ready;
  logic [31:0] rs2_rob_v;

  // result bus and retire
  logic        cdb_valid;
  logic [ooo_params_pkg::rob_tag_w-1:0] cdb_rob;
  logic [31:0] cdb_rd_v;
  logic [ooo_params_pkg::rob_tag_w-1:0] commit_rob;

  fetch fetch (.*);

  dispatch dispatch (.*);

  alu_rs alu_rs (.*);

  rob rob (.*);

  regfile_scoreboard regfile_scoreboard (.*);

endmodule

`default_nettype wire

// File: logic/dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch (
  input  logic instr_valid,
  input  logic rs_full,
  input  logic rob_full,
  output logic instr_pop,
  output logic rs_issue,
  output logic rob_push
);

  logic go;

  // in order; head waits until both targets have room
  assign go = instr_valid && !rs_full && !rob_full;

  // every supported op is an alu op
  assign instr_pop = go;
  assign rs_issue  = go;
  assign rob_push  = go;

endmodule

`default_nettype wire

// File: logic/fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] imem_rdata,
  input  logic        imem_resp,
  input  logic        instr_pop,
  output logic [31:0] imem_addr,
  output logic [3:0]  imem_rmask,
  output logic        instr_valid,
  output logic [31:0] issue_pc,
  output logic [6:0]  issue_opcode,
  output logic [2:0]  issue_funct3,
  output logic [6:0]  issue_funct7,
  output logic [31:0] issue_imm,
  output logic [4:0]  issue_rs1_s,
  output logic [4:0]  issue_rs2_s,
  output logic [4:0]  issue_rd_s
);

  logic [31:0] pc;
  logic        pending;
  logic        req;
  logic [31:0] q_word [ooo_params_pkg::queue_depth];
  logic [31:0] q_pc [ooo_params_pkg::queue_depth];
  logic [ooo_params_pkg::queue_ptr_w-1:0] q_head;
  logic [ooo_params_pkg::queue_ptr_w-1:0] q_tail;
  logic [ooo_params_pkg::queue_ptr_w:0]   q_count;
  rv32i_types::instr_t head_word;

  // no request while one is in flight or the queue has no room
  assign req        = !pending && (q_count < ooo_params_pkg::queue_depth);
  assign imem_addr  = pc;
  assign imem_rmask = req ? 4'hf : 4'h0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc      <= '0;
      pending <= 1'b0;
      q_head  <= '0;
      q_tail  <= '0;
      q_count <= '0;
    end else begin
      if (req) begin
        pc      <= pc + 32'd4;
        pending <= 1'b1;
      end else if (imem_resp) begin
        pending <= 1'b0;
      end
      if (imem_resp) begin
        q_tail <= q_tail + 1'b1;
      end
      if (instr_pop) begin
        q_head <= q_head + 1'b1;
      end
      if (imem_resp && !instr_pop) begin
        q_count <= q_count + 1'b1;
      end else if (!imem_resp && instr_pop) begin
        q_count <= q_count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (imem_resp) begin
      q_word[q_tail] <= imem_rdata;
      // pc has already stepped past this request
      q_pc[q_tail]   <= pc - 32'd4;
    end
  end

  // head decode
  assign head_word    = q_word[q_head];
  assign instr_valid  = q_count != '0;
  assign issue_pc     = q_pc[q_head];
  assign issue_opcode = head_word.r.opcode;
  assign issue_funct3 = head_word.r.funct3;
  assign issue_funct7 = head_word.r.funct7;
  assign issue_rd_s   = head_word.r.rd;

  always_comb begin
    if (head_word.r.opcode == rv32i_types::op_lui) begin
      issue_imm   = {head_word.i.imm12, head_word.i.rs1, head_word.i.funct3, 12'h000};
      issue_rs1_s = 5'd0;
    end else begin
      issue_imm   = {{20{head_word.i.imm12[11]}}, head_word.i.imm12};
      issue_rs1_s = head_word.i.rs1;
    end
    issue_rs2_s = (head_word.r.opcode == rv32i_types::op_reg) ? head_word.r.rs2 : 5'd0;
  end

endmodule

`default_nettype wire

// File: logic/ooo_params_pkg.sv
`default_nettype none

package ooo_params_pkg;

  localparam int queue_depth = 4;
  localparam int queue_ptr_w = $clog2(queue_depth);
  localparam int rs_depth    = 3;
  localparam int rs_idx_w    = $clog2(rs_depth);
  localparam int rob_depth   = 8;
  localparam int rob_tag_w   = $clog2(rob_depth);

endpackage

`default_nettype wire

// File: logic/regfile_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module regfile_scoreboard (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rob_push,
  input  logic [4:0]  issue_rd_s,
  input  logic [ooo_params_pkg::rob_tag_w-1:0] issue_rob,
  input  logic [4:0]  issue_rs1_s,
  input  logic [4:0]  issue_rs2_s,
  input  logic        commit_valid,
  input  logic [4:0]  commit_rd_s,
  input  logic [31:0] commit_rd_v,
  input  logic [ooo_params_pkg::rob_tag_w-1:0] commit_rob,
  output logic [31:0] rs1_v,
  output logic        rs1_ready,
  output logic [ooo_params_pkg::rob_tag_w-1:0] rs1_rob,
  output logic [31:0] rs2_v,
  output logic        rs2_ready,
  output logic [ooo_params_pkg::rob_tag_w-1:0] rs2_rob
);

  logic [31:0] regs [32];
  logic        busy [32];
  logic [ooo_params_pkg::rob_tag_w-1:0] tag [32];

  assign rs1_v     = regs[issue_rs1_s];
  assign rs1_ready = !busy[issue_rs1_s];
  assign rs1_rob   = tag[issue_rs1_s];
  assign rs2_v     = regs[issue_rs2_s];
  assign rs2_ready = !busy[issue_rs2_s];
  assign rs2_rob   = tag[issue_rs2_s];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
        busy[i] <= 1'b0;
        tag[i]  <= '0;
      end
    end else begin
      // x0 stays zero and is never tracked
      if (commit_valid && commit_rd_s != 5'd0) begin
        regs[commit_rd_s] <= commit_rd_v;
        if (tag[commit_rd_s] == commit_rob) busy[commit_rd_s] <= 1'b0;
      end
      // later assignment, so a same-cycle producer wins
      if (rob_push && issue_rd_s != 5'd0) begin
        busy[issue_rd_s] <= 1'b1;
        tag[issue_rd_s]  <= issue_rob;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/rob.sv
`timescale 1ns/1ps
`default_nettype none

module rob (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rob_push,
  input  logic [31:0] issue_pc,
  input  logic [4:0]  issue_rd_s,
  input  logic        cdb_valid,
  input  logic [ooo_params_pkg::rob_tag_w-1:0] cdb_rob,
  input  logic [31:0] cdb_rd_v,
  input  logic [ooo_params_pkg::rob_tag_w-1:0] rs1_rob,
  input  logic [ooo_params_pkg::rob_tag_w-1:0] rs2_rob,
  output logic        rob_full,
  output logic [ooo_params_pkg::rob_tag_w-1:0] issue_rob,
  output logic        rs1_rob_ready,
  output logic [31:0] rs1_rob_v,
  output logic        rs2_rob_ready,
  output logic [31:0] rs2_rob_v,
  output logic        commit_valid,
  output logic [ooo_params_pkg::rob_tag_w-1:0] commit_rob,
  output logic [31:0] commit_pc,
  output logic [4:0]  commit_rd_s,
  output logic [31:0] commit_rd_v
);

  logic        done [ooo_params_pkg::rob_depth];
  logic [31:0] e_pc [ooo_params_pkg::rob_depth];
  logic [31:0] e_v [ooo_params_pkg::rob_depth];
  logic [4:0]  e_rd [ooo_params_pkg::rob_depth];
  logic [ooo_params_pkg::rob_tag_w-1:0] head;
  logic [ooo_params_pkg::rob_tag_w-1:0] tail;
  logic [ooo_params_pkg::rob_tag_w:0]   count;

  assign rob_full  = count == ooo_params_pkg::rob_depth;
  assign issue_rob = tail;

  // producer tags from the scoreboard always name a live entry
  assign rs1_rob_ready = done[rs1_rob];
  assign rs1_rob_v     = e_v[rs1_rob];
  assign rs2_rob_ready = done[rs2_rob];
  assign rs2_rob_v     = e_v[rs2_rob];

  assign commit_valid = (count != '0) && done[head];
  assign commit_rob   = head;
  assign commit_pc    = e_pc[head];
  assign commit_rd_s  = e_rd[head];
  assign commit_rd_v  = e_v[head];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < ooo_params_pkg::rob_depth; i++) done[i] <= 1'b0;
    end else begin
      if (cdb_valid) done[cdb_rob] <= 1'b1;
      if (rob_push) begin
        done[tail] <= 1'b0;
        tail       <= tail + 1'b1;
      end
      if (commit_valid) head <= head + 1'b1;
      if (rob_push && !commit_valid) begin
        count <= count + 1'b1;
      end else if (!rob_push && commit_valid) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rob_push) begin
      e_pc[tail] <= issue_pc;
      e_rd[tail] <= issue_rd_s;
    end
    if (cdb_valid) e_v[cdb_rob] <= cdb_rd_v;
  end

endmodule

`default_nettype wire

// File: logic/rv32i_types.sv
`default_nettype none

package rv32i_types;

  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_reg = 7'b0110011;

  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // one fetched word, read as r or i format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } instr_t;

endpackage

`default_nettype wire

// File: verilog.f
logic/rv32i_types.sv
logic/ooo_params_pkg.sv
logic/fetch.sv
logic/dispatch.sv
logic/alu_rs.sv
logic/rob.sv
logic/regfile_scoreboard.sv
logic/cpu.sv
bench/cpu_checker.sv
bench/cpu_tb.sv
